// File: Makefile
# Verilator build and run, write direction then read direction
TOP = tb_cmd_encoder

.PHONY: all lint clean

all:
	verilator --binary --assert -f sources.f --top-module $(TOP) -GIS_READ=0 -Mdir obj_wr -o sim
	./obj_wr/sim | tee sim_wr.log
	verilator --binary --assert -f sources.f --top-module $(TOP) -GIS_READ=1 -Mdir obj_rd -o sim
	./obj_rd/sim | tee sim_rd.log
	@grep -q "ALL TESTS PASSED" sim_wr.log || (echo "write run failed"; exit 1)
	@grep -q "ALL TESTS PASSED" sim_rd.log || (echo "read run failed"; exit 1)

lint:
	verilator --lint-only -Wall -f sources.f --top-module cmd_encoder_top

clean:
	rm -rf obj_wr obj_rd sim_wr.log sim_rd.log

// File: sources.f
verilog/link_pkg.sv
verilog/dma_pkg.sv
verilog/byte_run_splitter.sv
verilog/partial_queue.sv
verilog/partial_ctrl.sv
verilog/cmd_issue.sv
verilog/cmd_encoder_top.sv
testbench/tb_cmd_encoder.sv

// File: testbench/tb_cmd_encoder.sv
/* command encoder testbench */
`timescale 1ns/1ps

module tb_cmd_encoder;

   parameter bit IS_READ = 1'b0;

   // ~40 lines, a partial half runs ~20 cycles, back-pressure about doubles its test
   localparam int TIMEOUT_CYCLES = 2000;

   logic                          clk;
   logic                          rst_n;
   logic                          dma_valid_i;
   dma_pkg::dma_req_t             dma_req_i;
   logic [dma_pkg::LINE_BITS-1:0] dma_data_i;
   logic                          link_rdy_i;
   logic                          dma_ready_o;
   logic                          link_valid_o;
   link_pkg::link_cmd_t           link_cmd_o;
   logic [dma_pkg::LINE_BITS-1:0] link_data_o;

   // ========================================================================
   // reference model state
   // ========================================================================
   link_pkg::link_cmd_t prt_cmd_q [$];      // partial runs in link order
   logic [1023:0]       prt_data_q [$];
   link_pkg::link_cmd_t bp_cmd;             // bypass expected next cycle
   logic [1023:0]       bp_data;
   logic                bp_lo_only;         // 64B bypass, only low 512 bits defined
   logic                bypass_due;
   logic                rdy_random;         // randomize link credit
   integer              seed;
   int                  cycle_cnt;
   string               test_name;
   int                  test_checks;
   int                  test_errs;
   int                  total_checks;
   int                  total_errs;
   int                  tests_run;
   int                  tests_failed;

   cmd_encoder_top #(
      .IS_READ          (IS_READ),
      .QUEUE_DEPTH_LOG2 (5)
   ) dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .dma_valid_i  (dma_valid_i),
      .dma_req_i    (dma_req_i),
      .dma_data_i   (dma_data_i),
      .link_rdy_i   (link_rdy_i),
      .dma_ready_o  (dma_ready_o),
      .link_valid_o (link_valid_o),
      .link_cmd_o   (link_cmd_o),
      .link_data_o  (link_data_o)
   );

   always #10 clk = ~clk;                   // 20 ns period

   // cycle limit for a hung run
   initial
   begin
      while (cycle_cnt < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout, tests still running after %0d cycles", cycle_cnt);
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic check_value(input string what, input logic [1023:0] exp,
                              input logic [1023:0] act);
      begin
         test_checks++;
         if (act !== exp)
         begin
            test_errs++;
            $display("Fail %s %s: expected %0h actual %0h", test_name, what, exp, act);
         end
      end
   endtask

   task automatic report_problem(input string msg);
      begin
         test_errs++;
         $display("error in %s: %s", test_name, msg);
      end
   endtask

   task automatic compare_cmd(input link_pkg::link_cmd_t c, input logic [1023:0] d,
                              input logic lo_only);
      begin
         check_value("opcode", c.opcode, link_cmd_o.opcode);
         check_value("ea", c.ea, link_cmd_o.ea);
         check_value("afutag", c.afutag, link_cmd_o.afutag);
         check_value("dl", c.dl, link_cmd_o.dl);
         check_value("pl", c.pl, link_cmd_o.pl);
         if (lo_only)
            check_value("data", d[511:0], link_data_o[511:0]);
         else
            check_value("data", d, link_data_o);
      end
   endtask

   // link monitor, outputs are registered so the falling edge sees them settled
   always @(negedge clk)
   begin
      if (rst_n === 1'b1)
      begin
         if (bypass_due)
         begin
            bypass_due = 1'b0;
            if (link_valid_o !== 1'b1)
               report_problem("bypass command missing one cycle after acceptance");
            else
               compare_cmd(bp_cmd, bp_data, bp_lo_only);
         end
         else if (link_valid_o !== 1'b0)
         begin
            if (prt_cmd_q.size() == 0)
               report_problem("link command issued while none was expected");
            else
               compare_cmd(prt_cmd_q.pop_front(), prt_data_q.pop_front(), 1'b0);
         end
      end
   end

   // ========================================================================
   // stimulus helpers, all random numbers drawn in the main process
   // ========================================================================
   task automatic tick;
      begin
         @(negedge clk);
         link_rdy_i = rdy_random ? (($random(seed) & 1) != 0) : 1'b1;
      end
   endtask

   task automatic rand64(output logic [63:0] r);
      begin
         r[31:0]  = $random(seed);
         r[63:32] = $random(seed);
      end
   endtask

   task automatic fill_data(output logic [1023:0] d);
      int i;
      begin
         for (i = 0; i < 32; i++)
            d[32*i +: 32] = $random(seed);
      end
   endtask

   // force a mask to be neither empty nor full
   function automatic logic [63:0] partial_mask(input logic [63:0] r);
      begin
         if (r == 64'd0)
            partial_mask = 64'h8;
         else if (&r)
            partial_mask = r ^ 64'h10;
         else
            partial_mask = r;
      end
   endfunction

   task automatic random_half(output logic [63:0] m);
      logic [63:0] r;
      int          sel;
      begin
         rand64(r);
         sel = $random(seed) & 3;
         case (sel)
            0:       m = '0;
            1:       m = '1;
            default: m = partial_mask(r);
         endcase
      end
   endtask

   // aligned power-of-two runs, lowest set byte first, at most 32 bytes each
   task automatic expect_half(input logic [63:0] mask, input logic hi,
                              input dma_pkg::dma_req_t req, input logic [511:0] hdata);
      link_pkg::link_cmd_t c;
      logic [63:0]         left;
      logic [63:0]         ones;
      logic [4:0]          cnt;
      int                  p;
      int                  k;
      int                  t;
      int                  sz;
      begin
         left = mask;
         cnt  = 5'd0;                       // 5-bit field, wraps on long masks
         while (left != 64'd0)
         begin
            p = 0;
            while (!left[p])
               p++;
            k = 0;
            for (t = 1; t <= 5; t++)
            begin
               sz   = 1 << t;
               ones = (64'd1 << sz) - 64'd1;
               if ((p % sz) == 0 && (p + sz) <= 64 && ((left >> p) & ones) == ones)
                  k = t;
               else
                  break;
            end
            c.opcode = IS_READ ? link_pkg::OP_PR_RD_WNITC : link_pkg::OP_DMA_PR_W;
            c.dl     = link_pkg::DL_64B;
            c.pl     = k[2:0];
            c.afutag = {IS_READ, 1'b1, cnt, hi ? 2'b10 : 2'b01, req.tag};
            c.ea     = {req.line_addr, hi, p[5:0]};
            prt_cmd_q.push_back(c);
            prt_data_q.push_back({512'd0, hdata});
            left = left & ~(((64'd1 << (1 << k)) - 64'd1) << p);
            cnt  = cnt + 5'd1;
         end
      end
   endtask

   task automatic expect_line(input dma_pkg::dma_req_t req, input logic [1023:0] data);
      logic full_lo;
      logic full_hi;
      begin
         full_lo = &req.be[63:0];
         full_hi = &req.be[127:64];
         if (full_lo || full_hi)
         begin
            bp_cmd.opcode = IS_READ ? link_pkg::OP_RD_WNITC : link_pkg::OP_DMA_W;
            bp_cmd.pl     = 3'd0;
            bp_cmd.afutag = {IS_READ, 1'b0, 5'd0, full_hi, full_lo, req.tag};
            bp_cmd.dl     = (full_lo && full_hi) ? link_pkg::DL_128B : link_pkg::DL_64B;
            bp_lo_only    = !(full_lo && full_hi);
            bp_cmd.ea     = {req.line_addr, full_hi && !full_lo, 6'd0};
            bp_data       = (full_hi && !full_lo) ? {512'd0, data[1023:512]} : data;
            bypass_due    = 1'b1;
         end
         if (!full_lo && |req.be[63:0])     // low half runs go first
            expect_half(req.be[63:0], 1'b0, req, data[511:0]);
         if (!full_hi && |req.be[127:64])
            expect_half(req.be[127:64], 1'b1, req, data[1023:512]);
      end
   endtask

   // hold the line until the handshake, then drop valid for a cycle
   task automatic send_line(input logic [127:0] be);
      dma_pkg::dma_req_t req;
      logic [1023:0]     data;
      logic [63:0]       r;
      logic              taken;
      begin
         rand64(r);
         req.line_addr = r[56:0];
         req.tag       = r[63:57];
         req.be        = be;
         fill_data(data);
         taken = 1'b0;
         while (!taken)
         begin
            tick();
            dma_valid_i = 1'b1;
            dma_req_i   = req;
            dma_data_i  = data;
            #2;
            if (!link_rdy_i && dma_ready_o)
               report_problem("dma_ready_o high while link_rdy_i low");
            if (dma_ready_o === 1'b1)
            begin
               taken = 1'b1;
               expect_line(req, data);
            end
         end
         tick();
         dma_valid_i = 1'b0;
      end
   endtask

   task automatic start_test(input string name);
      begin
         test_name   = name;
         test_checks = 0;
         test_errs   = 0;
      end
   endtask

   task automatic finish_test;
      int idle;
      begin
         idle = 0;
         while (idle < 4)                   // a few quiet cycles catch stray commands
         begin
            tick();
            #1;
            if (bypass_due || prt_cmd_q.size() != 0)
               idle = 0;
            else
               idle++;
         end
         $display("test %s done, %0d checks, %0d errors", test_name, test_checks, test_errs);
         tests_run++;
         total_checks += test_checks;
         total_errs   += test_errs;
         if (test_errs != 0)
            tests_failed++;
      end
   endtask

   // ========================================================================
   // test sequence
   // ========================================================================
   initial
   begin
      int          i;
      logic [63:0] lo;
      logic [63:0] hi;
      clk          = 1'b0;
      rst_n        = 1'b0;
      dma_valid_i  = 1'b0;
      dma_req_i    = '0;
      dma_data_i   = '0;
      link_rdy_i   = 1'b0;
      seed         = 27;
      bypass_due   = 1'b0;
      rdy_random   = 1'b0;
      bp_cmd       = '0;
      bp_data      = '0;
      bp_lo_only   = 1'b0;
      cycle_cnt    = 0;
      tests_run    = 0;
      tests_failed = 0;
      total_checks = 0;
      total_errs   = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n      = 1'b1;
      link_rdy_i = 1'b1;

      start_test("reset_idle");             // quiet link, ready once credit is there
      for (i = 0; i < 10; i++)
      begin
         tick();
         #1;
         check_value("link_valid_o", 1'b0, link_valid_o);
         check_value("dma_ready_o", 1'b1, dma_ready_o);
      end
      finish_test();

      start_test("full_line");
      repeat (6) send_line('1);
      finish_test();

      start_test("single_half");            // odd lines carry the high half
      for (i = 0; i < 8; i++)
         send_line(i[0] ? {{64{1'b1}}, 64'd0} : {64'd0, {64{1'b1}}});
      finish_test();

      start_test("random_partial");         // both halves partial, low runs first
      repeat (10)
      begin
         rand64(lo);
         rand64(hi);
         send_line({partial_mask(hi), partial_mask(lo)});
      end
      finish_test();

      start_test("mixed_order");            // bypass ahead of the partial runs
      for (i = 0; i < 6; i++)
      begin
         rand64(lo);
         if (i[0])
            send_line({partial_mask(lo), {64{1'b1}}});
         else
            send_line({{64{1'b1}}, partial_mask(lo)});
      end
      finish_test();

      start_test("backpressure");
      rdy_random = 1'b1;
      repeat (8)
      begin
         random_half(lo);
         random_half(hi);
         send_line({hi, lo});
      end
      finish_test();
      rdy_random = 1'b0;

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, total_checks, total_errs);
      if (total_errs == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: verilog/byte_run_splitter.sv
/* splits a 64B byte mask into aligned power-of-two runs */
`timescale 1ns/1ps

module byte_run_splitter (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           load_i,
   input  logic [dma_pkg::HALF_BYTES-1:0] mask_i,
   input  logic                           en_i,
   output logic                           run_valid_o,
   output logic [2:0]                     run_pl_o,
   output logic [5:0]                     run_offset_o,
   output logic [4:0]                     run_count_o,
   output logic                           run_last_o
);

   logic [63:0] left_q;
   logic [4:0]  cnt_q;
   logic [5:0]  p;
   logic [2:0]  k;
   logic [63:0] ones;         // one run of 2^t bytes at bit 0
   logic [63:0] run_bits;
   logic        found;
   logic        stop;

   // lowest set byte and the largest aligned run starting there
   always_comb
   begin
      p     = 6'd0;
      found = 1'b0;
      ones  = '0;
      for (int i = 0; i < 64; i++)
         if (!found && left_q[i])
         begin
            p     = i[5:0];
            found = 1'b1;
         end
      k    = 3'd0;
      stop = 1'b0;
      for (int t = 1; t <= int'(link_pkg::MAX_RUN_LOG2); t++)
      begin
         ones = (64'd1 << (1 << t)) - 64'd1;
         if (!stop && ((int'(p) % (1 << t)) == 0) && (int'(p) + (1 << t) <= 64)
             && (((left_q >> p) & ones) == ones))
            k = t[2:0];
         else
            stop = 1'b1;
      end
      run_bits = ((64'd1 << (1 << k)) - 64'd1) << p;
   end

   assign run_valid_o  = en_i && !load_i && (left_q != 64'd0);
   assign run_pl_o     = k;
   assign run_offset_o = p;
   assign run_count_o  = cnt_q;
   assign run_last_o   = run_valid_o && ((left_q & ~run_bits) == 64'd0);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         left_q <= '0;
         cnt_q  <= '0;
      end
      else if (load_i)
      begin
         left_q <= mask_i;
         cnt_q  <= '0;
      end
      else if (run_valid_o)
      begin
         left_q <= left_q & ~run_bits;
         cnt_q  <= cnt_q + 5'd1;
      end
   end

endmodule

// File: verilog/cmd_encoder_top.sv
/* command encoder top */
`timescale 1ns/1ps

module cmd_encoder_top #(
   parameter bit IS_READ          = 1'b0,
   parameter int QUEUE_DEPTH_LOG2 = 5
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          dma_valid_i,
   input  dma_pkg::dma_req_t             dma_req_i,
   input  logic [dma_pkg::LINE_BITS-1:0] dma_data_i,
   input  logic                          link_rdy_i,
   output logic                          dma_ready_o,
   output logic                          link_valid_o,
   output link_pkg::link_cmd_t           link_cmd_o,
   output logic [dma_pkg::LINE_BITS-1:0] link_data_o
);

   logic                            bypass;
   logic                            push;
   dma_pkg::prt_entry_t             push_entry;
   logic [dma_pkg::LINE_BITS-1:0]   push_data;
   logic                            pop;
   dma_pkg::prt_entry_t             q_entry;
   logic [dma_pkg::LINE_BITS-1:0]   q_data;
   logic                            q_empty;
   logic                            q_half_full;
   logic                            load;
   logic [dma_pkg::HALF_BYTES-1:0]  mask;
   logic                            split_en;
   logic [1:0]                      prt_half;
   logic [dma_pkg::TAG_W-1:0]       prt_tag;
   logic [56:0]                     prt_addr;
   logic [dma_pkg::LINE_BITS/2-1:0] prt_data;
   logic                            run_valid;
   logic [2:0]                      run_pl;
   logic [5:0]                      run_offset;
   logic [4:0]                      run_count;
   logic                            run_last;

   cmd_issue #(.IS_READ(IS_READ)) u_issue (
      .clk          (clk),
      .rst_n        (rst_n),
      .dma_valid_i  (dma_valid_i),
      .dma_ready_i  (dma_ready_o),
      .dma_req_i    (dma_req_i),
      .dma_data_i   (dma_data_i),
      .run_valid_i  (run_valid),
      .run_pl_i     (run_pl),
      .run_offset_i (run_offset),
      .run_count_i  (run_count),
      .prt_half_i   (prt_half),
      .prt_tag_i    (prt_tag),
      .prt_addr_i   (prt_addr),
      .prt_data_i   (prt_data),
      .bypass_o     (bypass),
      .push_o       (push),
      .push_entry_o (push_entry),
      .push_data_o  (push_data),
      .link_valid_o (link_valid_o),
      .link_cmd_o   (link_cmd_o),
      .link_data_o  (link_data_o)
   );

   partial_queue #(.QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)) u_queue (
      .clk         (clk),
      .rst_n       (rst_n),
      .push_i      (push),
      .entry_i     (push_entry),
      .data_i      (push_data),
      .pop_i       (pop),
      .entry_o     (q_entry),
      .data_o      (q_data),
      .empty_o     (q_empty),
      .half_full_o (q_half_full)
   );

   partial_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .link_rdy_i  (link_rdy_i),
      .bypass_i    (bypass),
      .empty_i     (q_empty),
      .half_full_i (q_half_full),
      .entry_i     (q_entry),
      .data_i      (q_data),
      .run_last_i  (run_last),
      .pop_o       (pop),
      .load_o      (load),
      .mask_o      (mask),
      .split_en_o  (split_en),
      .prt_half_o  (prt_half),
      .prt_tag_o   (prt_tag),
      .prt_addr_o  (prt_addr),
      .prt_data_o  (prt_data),
      .dma_ready_o (dma_ready_o)
   );

   byte_run_splitter u_splitter (
      .clk          (clk),
      .rst_n        (rst_n),
      .load_i       (load),
      .mask_i       (mask),
      .en_i         (split_en),
      .run_valid_o  (run_valid),
      .run_pl_o     (run_pl),
      .run_offset_o (run_offset),
      .run_count_o  (run_count),
      .run_last_o   (run_last)
   );

endmodule

// File: verilog/cmd_issue.sv
/* bypass and partial command issue */
`timescale 1ns/1ps

module cmd_issue #(
   parameter bit IS_READ = 1'b0                  // 1: read opcodes, 0: write opcodes
) (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             dma_valid_i,
   input  logic                             dma_ready_i,
   input  dma_pkg::dma_req_t                dma_req_i,
   input  logic [dma_pkg::LINE_BITS-1:0]    dma_data_i,
   input  logic                             run_valid_i,
   input  logic [2:0]                       run_pl_i,
   input  logic [5:0]                       run_offset_i,
   input  logic [4:0]                       run_count_i,
   input  logic [1:0]                       prt_half_i,
   input  logic [dma_pkg::TAG_W-1:0]        prt_tag_i,
   input  logic [56:0]                      prt_addr_i,
   input  logic [dma_pkg::LINE_BITS/2-1:0]  prt_data_i,
   output logic                             bypass_o,
   output logic                             push_o,
   output dma_pkg::prt_entry_t              push_entry_o,
   output logic [dma_pkg::LINE_BITS-1:0]    push_data_o,
   output logic                             link_valid_o,
   output link_pkg::link_cmd_t              link_cmd_o,
   output logic [dma_pkg::LINE_BITS-1:0]    link_data_o
);

   localparam int HB = dma_pkg::LINE_BITS / 2;   // bits per half

   logic                          accept;
   logic                          cpl_hi, cpl_lo;  // half fully enabled
   logic                          prt_hi, prt_lo;  // half neither full nor empty
   link_pkg::link_cmd_t           cmd_d;
   logic [dma_pkg::LINE_BITS-1:0] data_d;

   assign accept = dma_valid_i && dma_ready_i;
   assign cpl_lo = &dma_req_i.be[63:0];
   assign cpl_hi = &dma_req_i.be[127:64];
   assign prt_lo = !cpl_lo && |dma_req_i.be[63:0];
   assign prt_hi = !cpl_hi && |dma_req_i.be[127:64];

   // any complete half goes out right away and wins over partial runs
   assign bypass_o = accept && (cpl_hi || cpl_lo);

   // ========================================================================
   // next command, bypass or the current partial run
   // ========================================================================
   always_comb
   begin
      if (bypass_o)
      begin
         cmd_d.opcode = IS_READ ? link_pkg::OP_RD_WNITC : link_pkg::OP_DMA_W;
         cmd_d.pl     = 3'd0;
         cmd_d.afutag = {IS_READ, 1'b0, 5'd0, cpl_hi, cpl_lo, dma_req_i.tag};
         if (cpl_hi && cpl_lo)
         begin
            cmd_d.dl = link_pkg::DL_128B;
            cmd_d.ea = {dma_req_i.line_addr, 7'd0};
            data_d   = dma_data_i;
         end
         else
         begin
            cmd_d.dl = link_pkg::DL_64B;
            cmd_d.ea = {dma_req_i.line_addr, cpl_hi, 6'd0};
            // lone high half moves down to the low 64 bytes
            data_d   = cpl_hi ? {dma_data_i[HB-1:0], dma_data_i[2*HB-1:HB]} : dma_data_i;
         end
      end
      else
      begin
         cmd_d.opcode = IS_READ ? link_pkg::OP_PR_RD_WNITC : link_pkg::OP_DMA_PR_W;
         cmd_d.pl     = run_pl_i;
         cmd_d.dl     = link_pkg::DL_64B;
         cmd_d.afutag = {IS_READ, 1'b1, run_count_i, prt_half_i, prt_tag_i};
         cmd_d.ea     = {prt_addr_i, prt_half_i[1], run_offset_i};  // byte offset in half
         data_d       = {{HB{1'b0}}, prt_data_i};
      end
   end

   // link valid and queue push, both one cycle after the event
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         link_valid_o <= 1'b0;
         push_o       <= 1'b0;
      end
      else
      begin
         link_valid_o <= bypass_o || run_valid_i;
         push_o       <= accept && (prt_hi || prt_lo);
      end
   end

   always_ff @(posedge clk)
   begin
      if (bypass_o || run_valid_i)
      begin
         link_cmd_o  <= cmd_d;
         link_data_o <= data_d;
      end
      if (accept)
      begin
         push_entry_o <= {prt_hi, prt_lo, dma_req_i.tag, dma_req_i.line_addr, dma_req_i.be};
         push_data_o  <= dma_data_i;                 // data rides beside the entry
      end
   end

   // splitter is held off by the control whenever a bypass is issued
   a_no_collision: assert property (@(posedge clk) disable iff (!rst_n)
      !(bypass_o && run_valid_i));

endmodule

// File: verilog/dma_pkg.sv
/* dma request definitions */
package dma_pkg;

   localparam int TAG_W      = 7;      // request tag width
   localparam int LINE_BITS  = 1024;   // one 128B line of data
   localparam int HALF_BYTES = 64;     // bytes per line half

   // request as seen on the dma side
   typedef struct packed {
      logic [56:0]      line_addr;     // ea[63:7]
      logic [TAG_W-1:0] tag;
      logic [127:0]     be;            // byte enable, one bit per byte
   } dma_req_t;

   // queued line with at least one partial half
   typedef struct packed {
      logic             has_high;      // high half is partial
      logic             has_low;       // low half is partial
      logic [TAG_W-1:0] tag;
      logic [56:0]      line_addr;
      logic [127:0]     be;
   } prt_entry_t;

   // partial control states
   typedef enum logic [2:0] {
      IDLE,
      LOAD,        // pop the queue
      CHECK,       // popped entry visible, pick first half
      LOW_HALF,
      HIGH_HALF
   } prt_state_e;

endpackage

// File: verilog/link_pkg.sv
/* link command definitions */
package link_pkg;

   // ========================================================================
   // opcodes, only those the encoder can issue
   // ========================================================================
   typedef enum logic [7:0] {
      OP_RD_WNITC    = 8'b0001_0000,   // read with no intent to cache
      OP_PR_RD_WNITC = 8'b0001_0010,   // partial read
      OP_DMA_W       = 8'b0010_0000,   // dma write, 64B or 128B
      OP_DMA_PR_W    = 8'b0011_0000    // dma partial write
   } link_opcode_e;

   // afutag, msb first:
   //   [15]    read flag
   //   [14]    partial flag
   //   [13:9]  run count within one 64B half
   //   [8:7]   half code, 11 = 128B, 01 = low 64B, 10 = high 64B
   //   [6:0]   request tag
   typedef struct packed {
      link_opcode_e opcode;
      logic [63:0]  ea;                // effective address
      logic [15:0]  afutag;
      logic [1:0]   dl;                // data length
      logic [2:0]   pl;                // partial length, log2 of bytes
   } link_cmd_t;

   // data length codes
   localparam logic [1:0] DL_128B = 2'b10;
   localparam logic [1:0] DL_64B  = 2'b01;

   // largest partial run is 2^5 = 32 bytes
   localparam logic [2:0] MAX_RUN_LOG2 = 3'd5;

endpackage

// File: verilog/partial_ctrl.sv
/* partial command control FSM */
`timescale 1ns/1ps

module partial_ctrl (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             link_rdy_i,
   input  logic                             bypass_i,
   input  logic                             empty_i,
   input  logic                             half_full_i,
   input  dma_pkg::prt_entry_t              entry_i,
   input  logic [dma_pkg::LINE_BITS-1:0]    data_i,
   input  logic                             run_last_i,
   output logic                             pop_o,
   output logic                             load_o,
   output logic [dma_pkg::HALF_BYTES-1:0]   mask_o,
   output logic                             split_en_o,
   output logic [1:0]                       prt_half_o,
   output logic [dma_pkg::TAG_W-1:0]        prt_tag_o,
   output logic [56:0]                      prt_addr_o,
   output logic [dma_pkg::LINE_BITS/2-1:0]  prt_data_o,
   output logic                             dma_ready_o
);

   localparam int HB = dma_pkg::LINE_BITS / 2;   // bits per half

   dma_pkg::prt_state_e           state_q;
   dma_pkg::prt_entry_t           entry_q;       // entry being split
   logic [dma_pkg::LINE_BITS-1:0] data_q;
   logic [1:0]                    half_q;        // 01 low, 10 high
   logic                          load_q;

   assign pop_o       = (state_q == dma_pkg::LOAD);
   assign load_o      = load_q;
   assign split_en_o  = link_rdy_i && !bypass_i
                        && (state_q == dma_pkg::LOW_HALF || state_q == dma_pkg::HIGH_HALF);
   assign dma_ready_o = link_rdy_i && (state_q == dma_pkg::IDLE) && !half_full_i;

   // high half mask and data stay latched for the second pass
   assign mask_o     = half_q[1] ? entry_q.be[127:64] : entry_q.be[63:0];
   assign prt_half_o = half_q;
   assign prt_tag_o  = entry_q.tag;
   assign prt_addr_o = entry_q.line_addr;
   assign prt_data_o = half_q[1] ? data_q[2*HB-1:HB] : data_q[HB-1:0];

   // ========================================================================
   // state machine, one half at a time through the splitter
   // ========================================================================
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= dma_pkg::IDLE;
         half_q  <= 2'b00;
         load_q  <= 1'b0;
      end
      else
      begin
         load_q <= 1'b0;                         // strobe lasts one cycle
         case (state_q)
            dma_pkg::IDLE:
               if (!empty_i)
                  state_q <= dma_pkg::LOAD;
            dma_pkg::LOAD:
               state_q <= dma_pkg::CHECK;        // popped entry shows up next cycle
            dma_pkg::CHECK:
            begin
               load_q <= 1'b1;
               if (entry_i.has_low)              // low half goes first
               begin
                  state_q <= dma_pkg::LOW_HALF;
                  half_q  <= 2'b01;
               end
               else
               begin
                  state_q <= dma_pkg::HIGH_HALF;
                  half_q  <= 2'b10;
               end
            end
            dma_pkg::LOW_HALF:
               if (run_last_i)
               begin
                  if (entry_q.has_high)
                  begin
                     state_q <= dma_pkg::HIGH_HALF;
                     half_q  <= 2'b10;
                     load_q  <= 1'b1;
                  end
                  else
                     state_q <= empty_i ? dma_pkg::IDLE : dma_pkg::LOAD;
               end
            dma_pkg::HIGH_HALF:
               if (run_last_i)
                  state_q <= empty_i ? dma_pkg::IDLE : dma_pkg::LOAD;
            default:
               state_q <= dma_pkg::IDLE;
         endcase
      end
   end

   // entry and data captured when the popped entry is visible
   always_ff @(posedge clk)
   begin
      if (state_q == dma_pkg::CHECK)
      begin
         entry_q <= entry_i;
         data_q  <= data_i;
      end
   end

   a_load_pulse: assert property (@(posedge clk) disable iff (!rst_n) load_o |=> !load_o);

endmodule

// File: verilog/partial_queue.sv
/* partial entry queue */
`timescale 1ns/1ps

module partial_queue #(
   parameter int QUEUE_DEPTH_LOG2 = 5
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          push_i,
   input  dma_pkg::prt_entry_t           entry_i,
   input  logic [dma_pkg::LINE_BITS-1:0] data_i,
   input  logic                          pop_i,
   output dma_pkg::prt_entry_t           entry_o,
   output logic [dma_pkg::LINE_BITS-1:0] data_o,
   output logic                          empty_o,
   output logic                          half_full_o
);

   localparam int DEPTH = 1 << QUEUE_DEPTH_LOG2;

   dma_pkg::prt_entry_t           entry_mem [DEPTH];
   logic [dma_pkg::LINE_BITS-1:0] data_mem  [DEPTH];
   logic [QUEUE_DEPTH_LOG2:0]     wr_ptr, rd_ptr;    // extra msb tells full from empty
   logic [QUEUE_DEPTH_LOG2:0]     count;
   logic                          full;

   assign count       = wr_ptr - rd_ptr;
   assign full        = count[QUEUE_DEPTH_LOG2];
   assign empty_o     = (count == '0);
   assign half_full_o = |count[QUEUE_DEPTH_LOG2 -: 2];   // depth/2 or more

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push_i) wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // storage and registered read, data valid the cycle after pop
   always_ff @(posedge clk)
   begin
      if (push_i)
      begin
         entry_mem[wr_ptr[QUEUE_DEPTH_LOG2-1:0]] <= entry_i;
         data_mem[wr_ptr[QUEUE_DEPTH_LOG2-1:0]]  <= data_i;
      end
      if (pop_i)
      begin
         entry_o <= entry_mem[rd_ptr[QUEUE_DEPTH_LOG2-1:0]];
         data_o  <= data_mem[rd_ptr[QUEUE_DEPTH_LOG2-1:0]];
      end
   end

   // ready throttling upstream keeps headroom, control only pops when not empty
   a_no_overflow:  assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);

endmodule
